//--- common/fpgaIo_cfg.svh
`ifndef FPGA_IO_CFG_SVH
`define FPGA_IO_CFG_SVH

// high address byte that selects the board I/O page
`define IO_PAGE 8'h80

// offsets within the I/O page

// eight digit registers start here
`define SEG_BASE 0

// LED bytes, one register each
`define LED_LEFT_OFS 8
`define LED_RIGHT_OFS 9

// first button byte, one button per offset, value in bit 0
`define BTN_BASE 10

// board sizes

`define NUM_DIGITS 8
`define NUM_BUTTONS 21

// glyph for "0", shown on every digit out of reset
`define RESET_GLYPH 8'h3F

`endif

//--- common/fpgaIoPkg.sv
`include "fpgaIo_cfg.svh"

package fpgaIoPkg;

  // processor bus
  typedef logic [15:0] busAddrT;
  typedef logic [7:0] ioOffsetT;
  typedef logic [7:0] byteT;

  // bit 7 is the decimal point, bits 6 down to 0 are segments g to a
  typedef logic [7:0] glyphT;

  // one bit per push button
  typedef logic [`NUM_BUTTONS-1:0] buttonVecT;

  // number of values with a defined glyph
  localparam int GLYPH_COUNT = 20;

  // shown for any value past the table
  localparam glyphT GLYPH_DP_ONLY = 8'h80;

  // hex digits 0-F, then H, w, o, r
  localparam glyphT GLYPH_CODES [GLYPH_COUNT] = '{
    8'h3F, 8'h06, 8'h5B, 8'h4F,
    8'h66, 8'h6D, 8'h7D, 8'h07,
    8'h7F, 8'h6F, 8'h77, 8'h7C,
    8'h39, 8'h5E, 8'h79, 8'h71,
    8'h76, 8'h3E, 8'h5C, 8'h50
  };

endpackage

//--- src/busDecoder.sv
`include "fpgaIo_cfg.svh"

module busDecoder (
  input  fpgaIoPkg::busAddrT  addrBus,
  input  logic                writeEn,
  input  logic                readEn,
  input  fpgaIoPkg::byteT     ioReadData,
  output logic                regWrite,
  output fpgaIoPkg::ioOffsetT offset,
  output fpgaIoPkg::byteT     dataOut
);

  import fpgaIoPkg::*;

  byteT pageByte;
  logic pageHit;
  logic readHit;

  // split the address into page and offset
  assign pageByte = addrBus[15:8];
  assign offset   = addrBus[7:0];

  // the only place that checks the page
  assign pageHit = (pageByte == byteT'(`IO_PAGE));

  // strobes are plain levels, so a hit simply gates them
  assign regWrite = writeEn & pageHit;
  assign readHit  = readEn & pageHit;

  // read-data return to the processor
  // bus floats to zero unless a page read is in progress
  always_comb begin
    if (readHit) begin
      dataOut = ioReadData;
    end else begin
      dataOut = '0;
    end
  end

endmodule

//--- src/buttonSync.sv
module buttonSync (
  input  logic                 clk,
  input  logic                 nrst,
  input  fpgaIoPkg::buttonVecT buttons,
  output fpgaIoPkg::buttonVecT btnSync
);

  import fpgaIoPkg::*;

  // first stage may go metastable
  buttonVecT stage1;

  // board buttons are asynchronous to clk
  always_ff @(posedge clk or negedge nrst) begin
    if (!nrst) begin
      stage1  <= '0;
      btnSync <= '0;
    end else begin
      stage1  <= buttons;
      // second stage settles before anyone reads it
      btnSync <= stage1;
    end
  end

endmodule

//--- ioDriver/segEncoder.sv
module segEncoder (
  input  fpgaIoPkg::byteT  value,
  output fpgaIoPkg::glyphT glyph
);

  import fpgaIoPkg::*;

  localparam byteT LAST_CODE = byteT'(GLYPH_COUNT - 1);

  // table holds 0-F and the letters H, w, o, r
  always_comb begin
    case (value) inside
      [8'd0 : LAST_CODE]: begin
        // only the low five bits are needed inside the range
        glyph = GLYPH_CODES[value[4:0]];
      end
      default: begin
        // anything else lights the decimal point alone
        glyph = GLYPH_DP_ONLY;
      end
    endcase
  end

endmodule

//--- ioDriver/ioDriver.sv
`include "fpgaIo_cfg.svh"

module ioDriver (
  input  logic                 clk,
  input  logic                 nrst,
  input  logic                 regWrite,
  input  fpgaIoPkg::ioOffsetT  offset,
  input  fpgaIoPkg::byteT      dataIn,
  input  fpgaIoPkg::buttonVecT btnSync,
  output fpgaIoPkg::byteT      ioReadData,
  output fpgaIoPkg::glyphT     seg0,
  output fpgaIoPkg::glyphT     seg1,
  output fpgaIoPkg::glyphT     seg2,
  output fpgaIoPkg::glyphT     seg3,
  output fpgaIoPkg::glyphT     seg4,
  output fpgaIoPkg::glyphT     seg5,
  output fpgaIoPkg::glyphT     seg6,
  output fpgaIoPkg::glyphT     seg7,
  output fpgaIoPkg::byteT      ledLeft,
  output fpgaIoPkg::byteT      ledRight
);

  import fpgaIoPkg::*;

  localparam int DIGIT_IDX_W = $clog2(`NUM_DIGITS);
  localparam int BTN_IDX_W   = $clog2(`NUM_BUTTONS);

  glyphT    encodedGlyph;
  glyphT    digitRegs [`NUM_DIGITS];
  ioOffsetT digitSel;
  ioOffsetT btnSel;
  logic     digitHit;
  logic     btnHit;

  // every digit write goes through the encoder
  segEncoder uSegEncoder (
    .value (dataIn),
    .glyph (encodedGlyph)
  );

  // offsets relative to each register group
  // out-of-range offsets wrap high and miss the bound check
  assign digitSel = offset - ioOffsetT'(`SEG_BASE);
  assign btnSel   = offset - ioOffsetT'(`BTN_BASE);

  assign digitHit = (digitSel < ioOffsetT'(`NUM_DIGITS));
  assign btnHit   = (btnSel < ioOffsetT'(`NUM_BUTTONS));

  // digit registers hold the glyph, not the raw value
  always_ff @(posedge clk or negedge nrst) begin
    if (!nrst) begin
      for (int i = 0; i < `NUM_DIGITS; i++) begin
        digitRegs[i] <= `RESET_GLYPH;
      end
    end else if (regWrite && digitHit) begin
      digitRegs[digitSel[DIGIT_IDX_W-1:0]] <= encodedGlyph;
    end
  end

  // LED bytes take dataIn as is
  always_ff @(posedge clk or negedge nrst) begin
    if (!nrst) begin
      ledLeft  <= '0;
      ledRight <= '0;
    end else if (regWrite) begin
      if (offset == ioOffsetT'(`LED_LEFT_OFS)) begin
        ledLeft <= dataIn;
      end
      if (offset == ioOffsetT'(`LED_RIGHT_OFS)) begin
        ledRight <= dataIn;
      end
    end
  end

  // digits are driven statically, no multiplexing
  assign seg0 = digitRegs[0];
  assign seg1 = digitRegs[1];
  assign seg2 = digitRegs[2];
  assign seg3 = digitRegs[3];
  assign seg4 = digitRegs[4];
  assign seg5 = digitRegs[5];
  assign seg6 = digitRegs[6];
  assign seg7 = digitRegs[7];

  // button read-back, one button per byte in bit 0
  // digit and LED registers are write-only
  always_comb begin
    ioReadData = '0;
    if (btnHit) begin
      ioReadData[0] = btnSync[btnSel[BTN_IDX_W-1:0]];
    end
  end

endmodule

//--- src/fpgaIoTop.sv
module fpgaIoTop (
  input  logic                 clk,
  input  logic                 nrst,
  input  fpgaIoPkg::busAddrT   addrBus,
  input  fpgaIoPkg::byteT      dataIn,
  input  logic                 writeEn,
  input  logic                 readEn,
  input  fpgaIoPkg::buttonVecT buttons,
  output fpgaIoPkg::byteT      dataOut,
  output fpgaIoPkg::glyphT     seg0,
  output fpgaIoPkg::glyphT     seg1,
  output fpgaIoPkg::glyphT     seg2,
  output fpgaIoPkg::glyphT     seg3,
  output fpgaIoPkg::glyphT     seg4,
  output fpgaIoPkg::glyphT     seg5,
  output fpgaIoPkg::glyphT     seg6,
  output fpgaIoPkg::glyphT     seg7,
  output fpgaIoPkg::byteT      ledLeft,
  output fpgaIoPkg::byteT      ledRight
);

  import fpgaIoPkg::*;

  logic      regWrite;
  ioOffsetT  offset;
  buttonVecT btnSync;
  byteT      ioReadData;

  // page match, write strobe and read return
  busDecoder uBusDecoder (
    .addrBus    (addrBus),
    .writeEn    (writeEn),
    .readEn     (readEn),
    .ioReadData (ioReadData),
    .regWrite   (regWrite),
    .offset     (offset),
    .dataOut    (dataOut)
  );

  buttonSync uButtonSync (
    .clk     (clk),
    .nrst    (nrst),
    .buttons (buttons),
    .btnSync (btnSync)
  );

  // digit and LED registers, button read-back
  ioDriver uIoDriver (
    .clk        (clk),
    .nrst       (nrst),
    .regWrite   (regWrite),
    .offset     (offset),
    .dataIn     (dataIn),
    .btnSync    (btnSync),
    .ioReadData (ioReadData),
    .seg0       (seg0),
    .seg1       (seg1),
    .seg2       (seg2),
    .seg3       (seg3),
    .seg4       (seg4),
    .seg5       (seg5),
    .seg6       (seg6),
    .seg7       (seg7),
    .ledLeft    (ledLeft),
    .ledRight   (ledRight)
  );

endmodule

//--- tb/ioChecker.sv
`include "fpgaIo_cfg.svh"

module ioChecker (
  input logic                clk,
  input logic                nrst,
  input fpgaIoPkg::busAddrT  addrBus,
  input fpgaIoPkg::byteT     dataIn,
  input logic                writeEn,
  input fpgaIoPkg::byteT     dataOut,
  input fpgaIoPkg::glyphT    seg0,
  input fpgaIoPkg::glyphT    seg1,
  input fpgaIoPkg::glyphT    seg2,
  input fpgaIoPkg::glyphT    seg3,
  input fpgaIoPkg::glyphT    seg4,
  input fpgaIoPkg::glyphT    seg5,
  input fpgaIoPkg::glyphT    seg6,
  input fpgaIoPkg::glyphT    seg7,
  input fpgaIoPkg::byteT     ledLeft,
  input fpgaIoPkg::byteT     ledRight
);

  timeunit 1ns;
  timeprecision 1ps;

  import fpgaIoPkg::*;

  // expected register state
  glyphT modelSeg [`NUM_DIGITS];
  byteT  modelLedLeft;
  byteT  modelLedRight;

  int passCount = 0;
  int failCount = 0;

  // first mismatch seen in the current test
  int    mismatches;
  string firstSig;
  byteT  firstExp;
  byteT  firstAct;

  // seven-segment patterns, decimal point in bit 7
  function automatic glyphT glyphFor(input byteT value);
    case (value)
      8'd0:    return 8'h3F;
      8'd1:    return 8'h06;
      8'd2:    return 8'h5B;
      8'd3:    return 8'h4F;
      8'd4:    return 8'h66;
      8'd5:    return 8'h6D;
      8'd6:    return 8'h7D;
      8'd7:    return 8'h07;
      8'd8:    return 8'h7F;
      8'd9:    return 8'h6F;
      8'd10:   return 8'h77;
      8'd11:   return 8'h7C;
      8'd12:   return 8'h39;
      8'd13:   return 8'h5E;
      8'd14:   return 8'h79;
      8'd15:   return 8'h71;
      // letters H, w, o, r
      8'd16:   return 8'h76;
      8'd17:   return 8'h3E;
      8'd18:   return 8'h5C;
      8'd19:   return 8'h50;
      default: return 8'h80;
    endcase
  endfunction

  function automatic glyphT segSeen(input int idx);
    case (idx)
      0:       return seg0;
      1:       return seg1;
      2:       return seg2;
      3:       return seg3;
      4:       return seg4;
      5:       return seg5;
      6:       return seg6;
      default: return seg7;
    endcase
  endfunction

  // model follows the bus write rule
  always @(posedge clk or negedge nrst) begin
    if (!nrst) begin
      for (int i = 0; i < `NUM_DIGITS; i++) begin
        modelSeg[i] <= `RESET_GLYPH;
      end
      modelLedLeft  <= '0;
      modelLedRight <= '0;
    end else if (writeEn && (addrBus[15:8] == `IO_PAGE)) begin
      if (addrBus[7:0] < (`SEG_BASE + `NUM_DIGITS)) begin
        modelSeg[addrBus[7:0] - `SEG_BASE] <= glyphFor(dataIn);
      end else if (addrBus[7:0] == `LED_LEFT_OFS) begin
        modelLedLeft <= dataIn;
      end else if (addrBus[7:0] == `LED_RIGHT_OFS) begin
        modelLedRight <= dataIn;
      end
    end
  end

  task automatic compareByte(input string sig, input byteT expVal, input byteT actVal);
    if (actVal !== expVal) begin
      if (mismatches == 0) begin
        firstSig = sig;
        firstExp = expVal;
        firstAct = actVal;
      end
      mismatches++;
    end
  endtask

  // compares every output and prints the test's line
  task automatic checkTest(input string name, input byteT expOut);
    mismatches = 0;
    for (int i = 0; i < `NUM_DIGITS; i++) begin
      compareByte($sformatf("seg%0d", i), modelSeg[i], segSeen(i));
    end
    compareByte("ledLeft", modelLedLeft, ledLeft);
    compareByte("ledRight", modelLedRight, ledRight);
    compareByte("dataOut", expOut, dataOut);
    if (mismatches == 0) begin
      passCount++;
      $display("passed %s", name);
    end else begin
      failCount++;
      if (mismatches == 1) begin
        $display("FAILED %s %s expected %02h actual %02h",
                 name, firstSig, firstExp, firstAct);
      end else begin
        $display("FAILED %s %s expected %02h actual %02h, %0d more outputs wrong",
                 name, firstSig, firstExp, firstAct, mismatches - 1);
      end
    end
  endtask

  task automatic reportTotals();
    $display("tests passed: %0d, tests failed: %0d", passCount, failCount);
  endtask

endmodule

//--- tb/tbFpgaIo.sv
`include "fpgaIo_cfg.svh"

module tbFpgaIo;

  timeunit 1ns;
  timeprecision 1ps;

  import fpgaIoPkg::*;

  typedef enum {KIND_WRITE, KIND_READ, KIND_BUTTON} rowKindT;

  localparam int MAX_ROWS = 256;
  localparam buttonVecT BTN_PATTERN = 21'h0B5A6C;

  logic      clk;
  logic      nrst;
  busAddrT   addrBus;
  byteT      dataIn;
  logic      writeEn;
  logic      readEn;
  buttonVecT buttons;
  byteT      dataOut;
  glyphT     seg0, seg1, seg2, seg3, seg4, seg5, seg6, seg7;
  byteT      ledLeft;
  byteT      ledRight;

  // stimulus table, one entry per test
  string     rowName    [MAX_ROWS];
  rowKindT   rowKind    [MAX_ROWS];
  busAddrT   rowAddr    [MAX_ROWS];
  byteT      rowData    [MAX_ROWS];
  logic      rowStrobe  [MAX_ROWS];
  buttonVecT rowButtons [MAX_ROWS];
  byteT      rowExpOut  [MAX_ROWS];
  int        rowCount = 0;
  logic      tableBuilt = 1'b0;

  integer seed = 32'hbcb6;

  fpgaIoTop DUT (
    .clk (clk), .nrst (nrst), .addrBus (addrBus), .dataIn (dataIn),
    .writeEn (writeEn), .readEn (readEn), .buttons (buttons), .dataOut (dataOut),
    .seg0 (seg0), .seg1 (seg1), .seg2 (seg2), .seg3 (seg3),
    .seg4 (seg4), .seg5 (seg5), .seg6 (seg6), .seg7 (seg7),
    .ledLeft (ledLeft), .ledRight (ledRight)
  );

  ioChecker uChecker (
    .clk (clk), .nrst (nrst), .addrBus (addrBus), .dataIn (dataIn),
    .writeEn (writeEn), .dataOut (dataOut),
    .seg0 (seg0), .seg1 (seg1), .seg2 (seg2), .seg3 (seg3),
    .seg4 (seg4), .seg5 (seg5), .seg6 (seg6), .seg7 (seg7),
    .ledLeft (ledLeft), .ledRight (ledRight)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic addRow(input string name, input rowKindT kind, input busAddrT addr,
                        input byteT data, input logic strobe, input buttonVecT btn,
                        input byteT expOut);
    rowName[rowCount]    = name;
    rowKind[rowCount]    = kind;
    rowAddr[rowCount]    = addr;
    rowData[rowCount]    = data;
    rowStrobe[rowCount]  = strobe;
    rowButtons[rowCount] = btn;
    rowExpOut[rowCount]  = expOut;
    rowCount++;
  endtask

  task automatic buildTable();
    buttonVecT pattern;
    byteT      randVal;
    addRow("reset_state", KIND_READ, {`IO_PAGE, 8'(`BTN_BASE)}, 8'h00, 1'b1, '0, 8'h00);
    // every defined glyph on every digit, then one value past the table
    for (int d = 0; d < `NUM_DIGITS; d++) begin
      for (int v = 0; v < 20; v++) begin
        addRow($sformatf("digit%0d_val%0d", d, v), KIND_WRITE,
               {`IO_PAGE, 8'(`SEG_BASE + d)}, 8'(v), 1'b1, '0, 8'h00);
      end
      randVal = 8'(20 + ({$random(seed)} % 236));
      addRow($sformatf("digit%0d_rand%0d", d, randVal), KIND_WRITE,
             {`IO_PAGE, 8'(`SEG_BASE + d)}, randVal, 1'b1, '0, 8'h00);
    end
    addRow("led_left", KIND_WRITE, {`IO_PAGE, 8'(`LED_LEFT_OFS)}, 8'hA5, 1'b1, '0, 8'h00);
    addRow("led_right", KIND_WRITE, {`IO_PAGE, 8'(`LED_RIGHT_OFS)}, 8'h3C, 1'b1, '0, 8'h00);
    addRow("led_left_again", KIND_WRITE, {`IO_PAGE, 8'(`LED_LEFT_OFS)}, 8'h0F, 1'b1, '0,
           8'h00);
    // writes that must leave every output alone
    addRow("write_page81", KIND_WRITE, 16'h8103, 8'h05, 1'b1, '0, 8'h00);
    addRow("write_page00", KIND_WRITE, 16'h0008, 8'hFF, 1'b1, '0, 8'h00);
    addRow("write_page7f", KIND_WRITE, 16'h7F09, 8'h11, 1'b1, '0, 8'h00);
    addRow("write_no_strobe_digit", KIND_WRITE, 16'h8002, 8'h01, 1'b0, '0, 8'h00);
    addRow("write_no_strobe_led", KIND_WRITE, 16'h8009, 8'hEE, 1'b0, '0, 8'h00);
    // one pattern and its inverse, so each button reads both levels
    for (int round = 0; round < 2; round++) begin
      pattern = (round == 0) ? BTN_PATTERN : ~BTN_PATTERN;
      addRow($sformatf("buttons_set%0d", round), KIND_BUTTON, {`IO_PAGE, 8'(`BTN_BASE)},
             8'h00, 1'b1, pattern, {7'b0, pattern[0]});
      for (int b = 1; b < `NUM_BUTTONS; b++) begin
        addRow($sformatf("button%0d_read%0d", b, round), KIND_READ,
               {`IO_PAGE, 8'(`BTN_BASE + b)}, 8'h00, 1'b1, pattern, {7'b0, pattern[b]});
      end
    end
    // buttons 0 and 1 now read high, the rows below must still see zero
    for (int o = 0; o < `BTN_BASE; o++) begin
      addRow($sformatf("read_ofs%0d", o), KIND_READ, {`IO_PAGE, 8'(o)}, 8'h00, 1'b1,
             pattern, 8'h00);
    end
    addRow("read_ofs31", KIND_READ, 16'h801F, 8'h00, 1'b1, pattern, 8'h00);
    addRow("read_ofs32", KIND_READ, 16'h8020, 8'h00, 1'b1, pattern, 8'h00);
    addRow("read_ofs128", KIND_READ, 16'h8080, 8'h00, 1'b1, pattern, 8'h00);
    addRow("read_ofs255", KIND_READ, 16'h80FF, 8'h00, 1'b1, pattern, 8'h00);
    addRow("read_page81", KIND_READ, 16'h810A, 8'h00, 1'b1, pattern, 8'h00);
    addRow("read_page00", KIND_READ, 16'h000B, 8'h00, 1'b1, pattern, 8'h00);
    addRow("read_page7f", KIND_READ, 16'h7F0A, 8'h00, 1'b1, pattern, 8'h00);
    addRow("read_no_strobe", KIND_READ, 16'h800A, 8'h00, 1'b0, pattern, 8'h00);
  endtask

  // entered and left 1 ns after a rising edge
  task automatic applyRow(input int idx);
    if (rowKind[idx] == KIND_WRITE) begin
      addrBus = rowAddr[idx];
      dataIn  = rowData[idx];
      writeEn = rowStrobe[idx];
      readEn  = 1'b0;
      @(posedge clk);
      #1;
      writeEn = 1'b0;
      uChecker.checkTest(rowName[idx], rowExpOut[idx]);
    end else begin
      if (rowKind[idx] == KIND_BUTTON) begin
        buttons = rowButtons[idx];
        // two synchronizer stages plus one spare edge
        repeat (3) @(posedge clk);
        #1;
      end
      addrBus = rowAddr[idx];
      writeEn = 1'b0;
      readEn  = rowStrobe[idx];
      // read path is combinational
      #2;
      uChecker.checkTest(rowName[idx], rowExpOut[idx]);
      @(posedge clk);
      #1;
      readEn = 1'b0;
    end
  endtask

  initial begin
    nrst    = 1'b0;
    addrBus = '0;
    dataIn  = '0;
    writeEn = 1'b0;
    readEn  = 1'b0;
    buttons = '0;
    buildTable();
    tableBuilt = 1'b1;
    repeat (5) @(posedge clk);
    #1;
    nrst = 1'b1;
    for (int i = 0; i < rowCount; i++) begin
      applyRow(i);
    end
    uChecker.reportTotals();
    if (uChecker.failCount == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

  // no row needs more than six cycles
  initial begin
    wait (tableBuilt);
    repeat (rowCount * 6 + 20) @(posedge clk);
    $display("timeout: the run did not finish within %0d clock cycles", rowCount * 6 + 20);
    $display("RESULT: FAIL");
    $finish;
  end

endmodule

//--- project.f
+incdir+common
common/fpgaIoPkg.sv
src/busDecoder.sv
src/buttonSync.sv
ioDriver/segEncoder.sv
ioDriver/ioDriver.sv
src/fpgaIoTop.sv
tb/ioChecker.sv
tb/tbFpgaIo.sv

//--- Bender.yml
package:
  name: fpga_io

export_include_dirs:
  - common

sources:
  - files:
      - common/fpgaIoPkg.sv
      - src/busDecoder.sv
      - src/buttonSync.sv
      - ioDriver/segEncoder.sv
      - ioDriver/ioDriver.sv
      - src/fpgaIoTop.sv
  - target: test
    files:
      - tb/ioChecker.sv
      - tb/tbFpgaIo.sv
